/* Bender.yml */
package:
  name: divsqrt_multi

sources:
  - include_dirs:
      - logic
    files:
      - logic/divsqrt_pkg.sv
      - logic/divsqrt_if.sv
      - logic/divsqrt_inp_stage.sv
      - logic/divsqrt_ctrl.sv
      - logic/divsqrt_iter.sv
      - logic/divsqrt_multi.sv
  - target: test
    include_dirs:
      - logic
    files:
      - verif/divsqrt_assert.sv
      - verif/tb_divsqrt_multi.sv

/* flist.f */
+incdir+logic
logic/divsqrt_pkg.sv
logic/divsqrt_if.sv
logic/divsqrt_inp_stage.sv
logic/divsqrt_ctrl.sv
logic/divsqrt_iter.sv
logic/divsqrt_multi.sv
verif/divsqrt_assert.sv
verif/tb_divsqrt_multi.sv

/* logic/divsqrt_ctrl.sv */
`timescale 1ns/1ps
`include "divsqrt_macros.svh"

module divsqrt_ctrl (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  input  logic                       flush_i,
  // Request from input stage
  divsqrt_req_if.consumer            req,
  // Engine
  divsqrt_unit_if.master             unit,
  // Downstream handshake
  output logic                       out_valid_o,
  input  logic                       out_ready_i,
  output logic [`DIVSQRT_DATA_W-1:0] result_o,
  output logic                       dz_o,
  output logic [`DIVSQRT_TAG_W-1:0]  tag_o,
  // Work pending anywhere in the unit
  output logic                       busy_o
);
  import divsqrt_pkg::*;

  ctrl_state_e                state_q, state_d;
  logic                       fsm_ready;
  logic                       out_valid;
  logic                       op_start;
  logic                       hold_en;
  logic [`DIVSQRT_TAG_W-1:0]  tag_q;
  logic [`DIVSQRT_DATA_W-1:0] held_result_q;
  logic                       held_dz_q;

  // --------------------
  // Start gating
  // --------------------
  // Engine must be idle before a request is taken
  assign req.ready = fsm_ready & unit.unit_ready;
  assign op_start  = req.valid & req.ready & ~flush_i;

  assign unit.start_div  = op_start & (req.op == OP_DIV);
  // Unknown opcodes fall into the square root
  assign unit.start_sqrt = op_start & (req.op != OP_DIV);
  assign unit.opa        = req.opa;
  assign unit.opb        = req.opb;
  assign unit.kill       = flush_i;

  // --------------------
  // Control FSM
  // --------------------
  // Ready and valid decode from the current state
  always_comb begin : fsm_out
    fsm_ready = 1'b0;
    out_valid = 1'b0;
    unique case (state_q)
      ST_IDLE: fsm_ready = 1'b1;
      ST_BUSY: begin
        if (unit.done) begin
          out_valid = 1'b1;
          // Slot frees up only if the result leaves now
          fsm_ready = out_ready_i;
        end
      end
      ST_HOLD: begin
        out_valid = 1'b1;
        fsm_ready = out_ready_i;
      end
      default: fsm_ready = 1'b0;
    endcase
  end

  always_comb begin : fsm_next
    state_d = state_q;
    unique case (state_q)
      ST_IDLE: begin
        if (op_start) state_d = ST_BUSY;
      end
      ST_BUSY: begin
        if (unit.done) begin
          if (!out_ready_i) state_d = ST_HOLD;
          else if (op_start) state_d = ST_BUSY;
          else state_d = ST_IDLE;
        end
      end
      ST_HOLD: begin
        if (out_ready_i) state_d = op_start ? ST_BUSY : ST_IDLE;
      end
      default: state_d = ST_IDLE;
    endcase
    // Flush wins over everything
    if (flush_i) state_d = ST_IDLE;
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // --------------------
  // Tag and hold register
  // --------------------
  // Tag follows the operation from its start
  always_ff @(posedge clk_i) begin
    if (op_start) tag_q <= req.tag;
  end

  // Park the result when downstream stalls in the done cycle
  assign hold_en = (state_q == ST_BUSY) & unit.done & ~out_ready_i;

  always_ff @(posedge clk_i) begin
    if (hold_en) begin
      held_result_q <= unit.result;
      held_dz_q     <= unit.dz;
    end
  end

  // Output select
  assign out_valid_o = out_valid & ~flush_i;
  assign result_o    = (state_q == ST_HOLD) ? held_result_q : unit.result;
  assign dz_o        = (state_q == ST_HOLD) ? held_dz_q : unit.dz;
  assign tag_o       = tag_q;
  assign busy_o      = req.valid | (state_q != ST_IDLE);

endmodule

/* logic/divsqrt_if.sv */
`timescale 1ns/1ps
`include "divsqrt_macros.svh"

// Registered request from input stage to control
interface divsqrt_req_if;
  logic                       valid;
  logic                       ready;
  divsqrt_pkg::divsqrt_op_e   op;
  logic [`DIVSQRT_DATA_W-1:0] opa;
  logic [`DIVSQRT_DATA_W-1:0] opb;
  logic [`DIVSQRT_TAG_W-1:0]  tag;

  // Input stage side
  modport producer (output valid, op, opa, opb, tag, input ready);
  // Control side
  modport consumer (input valid, op, opa, opb, tag, output ready);
endinterface

// Start and completion signalling between control and engine
interface divsqrt_unit_if;
  // Control to engine
  logic                       start_div;
  logic                       start_sqrt;
  logic [`DIVSQRT_DATA_W-1:0] opa;
  logic [`DIVSQRT_DATA_W-1:0] opb;
  logic                       kill;
  // Engine to control
  logic [`DIVSQRT_DATA_W-1:0] result;
  logic                       dz;
  logic                       unit_ready;
  logic                       done;

  modport master (
    output start_div, start_sqrt, opa, opb, kill,
    input  result, dz, unit_ready, done
  );
  modport engine (
    input  start_div, start_sqrt, opa, opb, kill,
    output result, dz, unit_ready, done
  );
endinterface

/* logic/divsqrt_inp_stage.sv */
`timescale 1ns/1ps
`include "divsqrt_macros.svh"

module divsqrt_inp_stage (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  input  logic                       flush_i,
  // Upstream handshake
  input  logic                       in_valid_i,
  output logic                       in_ready_o,
  input  divsqrt_pkg::divsqrt_op_e   op_i,
  input  logic [`DIVSQRT_DATA_W-1:0] opa_i,
  input  logic [`DIVSQRT_DATA_W-1:0] opb_i,
  input  logic [`DIVSQRT_TAG_W-1:0]  tag_i,
  // Registered request towards control
  divsqrt_req_if.producer            req
);
  import divsqrt_pkg::*;

  logic                       valid_q;
  divsqrt_op_e                op_q;
  logic [`DIVSQRT_DATA_W-1:0] opa_q;
  logic [`DIVSQRT_DATA_W-1:0] opb_q;
  logic [`DIVSQRT_TAG_W-1:0]  tag_q;
  logic                       load;

  // Advance when downstream takes the item or the stage only holds a bubble
  assign in_ready_o = req.ready | ~valid_q;
  // Payload enable
  assign load = in_ready_o & in_valid_i;

  // Valid bit, flush kills the buffered item
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      valid_q <= 1'b0;
    end else if (flush_i) begin
      valid_q <= 1'b0;
    end else if (in_ready_o) begin
      valid_q <= in_valid_i;
    end
  end

  // Payload registers
  // Stable while valid is up and downstream stalls
  always_ff @(posedge clk_i) begin
    if (load) begin
      op_q  <= op_i;
      opa_q <= opa_i;
      opb_q <= opb_i;
      tag_q <= tag_i;
    end
  end

  assign req.valid = valid_q;
  assign req.op    = op_q;
  assign req.opa   = opa_q;
  assign req.opb   = opb_q;
  assign req.tag   = tag_q;

endmodule

/* logic/divsqrt_iter.sv */
`timescale 1ns/1ps
`include "divsqrt_macros.svh"

module divsqrt_iter (
  input  logic           clk_i,
  input  logic           rst_n_i,
  divsqrt_unit_if.engine unit
);
  import divsqrt_pkg::*;

  localparam int unsigned W     = `DIVSQRT_DATA_W;
  localparam int unsigned RS    = `DIVSQRT_ROOT_STEPS;
  localparam int unsigned CNT_W = $clog2(W);

  iter_state_e      state_q;
  logic [CNT_W-1:0] cnt_q;
  logic             last_step;
  logic             div_en, sqrt_en;
  // Remainder, quotient or radicand, divisor, root
  logic [W-1:0]     rem_q, quo_q, dvs_q;
  logic [RS-1:0]    root_q;
  logic [W-1:0]     rem_d, quo_d;
  logic [RS-1:0]    root_d;
  // Step inputs, operands while idle
  logic [W-1:0]     src_rem, src_quo, src_dvs;
  logic [RS-1:0]    src_root;
  logic [W:0]       div_sh, div_diff;
  logic             div_fit;
  logic [RS+3:0]    sq_sh, sq_trial, sq_diff;
  logic             sq_fit;

  // --------------------
  // Sequencing
  // --------------------
  // First step runs in the start cycle, done sits on the final count
  assign last_step = (state_q == IT_DIV) ? (cnt_q == CNT_W'(W - 1))
                                         : (cnt_q == CNT_W'(RS - 1));

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= IT_IDLE;
      cnt_q   <= '0;
    end else if (unit.kill) begin
      state_q <= IT_IDLE;
      cnt_q   <= '0;
    end else begin
      unique case (state_q)
        IT_IDLE: begin
          cnt_q <= '0;
          if (unit.start_div) state_q <= IT_DIV;
          else if (unit.start_sqrt) state_q <= IT_SQRT;
        end
        IT_DIV, IT_SQRT: begin
          if (last_step) begin
            state_q <= IT_IDLE;
            cnt_q   <= '0;
          end else begin
            cnt_q <= cnt_q + CNT_W'(1);
          end
        end
        default: state_q <= IT_IDLE;
      endcase
    end
  end

  assign div_en  = unit.start_div | ((state_q == IT_DIV) & ~last_step);
  assign sqrt_en = unit.start_sqrt | ((state_q == IT_SQRT) & ~last_step);

  // --------------------
  // Datapath
  // --------------------
  assign src_rem  = (state_q == IT_IDLE) ? '0 : rem_q;
  assign src_quo  = (state_q == IT_IDLE) ? unit.opa : quo_q;
  assign src_dvs  = (state_q == IT_IDLE) ? unit.opb : dvs_q;
  assign src_root = (state_q == IT_IDLE) ? '0 : root_q;

  // Restoring divide, shift in one dividend bit and try the subtract
  // Zero divisor always fits, so the quotient saturates to all ones
  assign div_sh   = {src_rem, src_quo[W-1]};
  assign div_diff = div_sh - {1'b0, src_dvs};
  assign div_fit  = div_sh >= {1'b0, src_dvs};

  // Square root, bring down two radicand bits against 4*root + 1
  assign sq_sh    = {src_rem[RS+1:0], src_quo[W-1:W-2]};
  assign sq_trial = {2'b00, src_root, 2'b01};
  assign sq_diff  = sq_sh - sq_trial;
  assign sq_fit   = sq_sh >= sq_trial;

  always_comb begin : step_next
    rem_d  = rem_q;
    quo_d  = quo_q;
    root_d = root_q;
    if (div_en) begin
      rem_d = div_fit ? div_diff[W-1:0] : div_sh[W-1:0];
      quo_d = {src_quo[W-2:0], div_fit};
    end else if (sqrt_en) begin
      // Remainder stays below 2*root + 1
      rem_d  = {{(W-RS-2){1'b0}}, (sq_fit ? sq_diff[RS+1:0] : sq_sh[RS+1:0])};
      quo_d  = {src_quo[W-3:0], 2'b00};
      root_d = {src_root[RS-2:0], sq_fit};
    end
  end

  always_ff @(posedge clk_i) begin
    rem_q  <= rem_d;
    quo_q  <= quo_d;
    root_q <= root_d;
    if (unit.start_div) dvs_q <= unit.opb;
  end

  // Outputs
  assign unit.unit_ready = (state_q == IT_IDLE);
  assign unit.done       = ((state_q == IT_DIV) | (state_q == IT_SQRT)) & last_step &
                           ~unit.kill;
  assign unit.result     = (state_q == IT_SQRT) ? {{(W-RS){1'b0}}, root_q} : quo_q;
  assign unit.dz         = (state_q == IT_DIV) & (dvs_q == '0);

endmodule

/* logic/divsqrt_macros.svh */
`ifndef DIVSQRT_MACROS_SVH
`define DIVSQRT_MACROS_SVH

// Operand and result width
`define DIVSQRT_DATA_W 16

// Tag width, the tag returns unchanged with its result
`define DIVSQRT_TAG_W 4

// One root bit per step over two radicand bits
`define DIVSQRT_ROOT_STEPS (`DIVSQRT_DATA_W / 2)

`endif

/* logic/divsqrt_multi.sv */
`timescale 1ns/1ps
`include "divsqrt_macros.svh"

module divsqrt_multi (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  // Input handshake
  input  logic                       in_valid_i,
  output logic                       in_ready_o,
  input  divsqrt_pkg::divsqrt_op_e   op_i,
  input  logic [`DIVSQRT_DATA_W-1:0] opa_i,
  input  logic [`DIVSQRT_DATA_W-1:0] opb_i,
  input  logic [`DIVSQRT_TAG_W-1:0]  tag_i,
  // Kills everything in flight
  input  logic                       flush_i,
  // Output handshake
  output logic                       out_valid_o,
  input  logic                       out_ready_i,
  output logic [`DIVSQRT_DATA_W-1:0] result_o,
  output logic                       dz_o,
  output logic [`DIVSQRT_TAG_W-1:0]  tag_o,
  output logic                       busy_o
);

  divsqrt_req_if  req_if ();
  divsqrt_unit_if unit_if ();

  // --------------------
  // Input register stage
  // --------------------
  divsqrt_inp_stage i_inp_stage (
    .clk_i      ( clk_i      ),
    .rst_n_i    ( rst_n_i    ),
    .flush_i    ( flush_i    ),
    .in_valid_i ( in_valid_i ),
    .in_ready_o ( in_ready_o ),
    .op_i       ( op_i       ),
    .opa_i      ( opa_i      ),
    .opb_i      ( opb_i      ),
    .tag_i      ( tag_i      ),
    .req        ( req_if     )
  );

  // Control FSM with hold register
  divsqrt_ctrl i_ctrl (
    .clk_i       ( clk_i       ),
    .rst_n_i     ( rst_n_i     ),
    .flush_i     ( flush_i     ),
    .req         ( req_if      ),
    .unit        ( unit_if     ),
    .out_valid_o ( out_valid_o ),
    .out_ready_i ( out_ready_i ),
    .result_o    ( result_o    ),
    .dz_o        ( dz_o        ),
    .tag_o       ( tag_o       ),
    .busy_o      ( busy_o      )
  );

  // One operation at a time in the engine
  divsqrt_iter i_iter (
    .clk_i   ( clk_i   ),
    .rst_n_i ( rst_n_i ),
    .unit    ( unit_if )
  );

endmodule

/* logic/divsqrt_pkg.sv */
package divsqrt_pkg;

  // --------------------
  // Opcodes
  // --------------------
  // Anything that is not a divide runs a square root
  typedef enum logic {
    OP_DIV  = 1'b0,
    OP_SQRT = 1'b1
  } divsqrt_op_e;

  // --------------------
  // FSM states
  // --------------------
  // Control FSM between request side and engine
  typedef enum logic [1:0] {
    ST_IDLE = 2'd0,
    ST_BUSY = 2'd1,
    ST_HOLD = 2'd2
  } ctrl_state_e;

  // Iterative engine
  typedef enum logic [1:0] {
    IT_IDLE = 2'd0,
    IT_DIV  = 2'd1,
    IT_SQRT = 2'd2
  } iter_state_e;

endpackage

/* verif/divsqrt_assert.sv */
`timescale 1ns/1ps
`include "divsqrt_macros.svh"

module divsqrt_assert (
  input logic                       clk_i,
  input logic                       rst_n_i,
  input logic                       in_valid_i,
  input logic                       in_ready_o,
  input divsqrt_pkg::divsqrt_op_e   op_i,
  input logic [`DIVSQRT_DATA_W-1:0] opa_i,
  input logic [`DIVSQRT_DATA_W-1:0] opb_i,
  input logic [`DIVSQRT_TAG_W-1:0]  tag_i,
  input logic                       flush_i,
  input logic                       out_valid_o,
  input logic                       out_ready_i,
  input logic [`DIVSQRT_DATA_W-1:0] result_o,
  input logic                       dz_o,
  input logic [`DIVSQRT_TAG_W-1:0]  tag_o,
  input logic                       busy_o
);
  import divsqrt_pkg::*;

  localparam int unsigned W = `DIVSQRT_DATA_W;

  int                        fail_cnt = 0;
  // In-order model, at most two operations are in flight
  logic [W-1:0]              exp_res_q [4];
  logic                      exp_dz_q [4];
  logic [`DIVSQRT_TAG_W-1:0] exp_tag_q [4];
  logic [1:0]                wr_ptr_q, rd_ptr_q;
  logic [2:0]                cnt_q;
  logic                      in_acc, out_acc, acc_idle;
  logic [W-1:0]              exp_res;
  logic                      exp_dz;
  logic [`DIVSQRT_TAG_W-1:0] exp_tag;
  // Outputs seen in the last stalled cycle
  logic                      stall_q;
  logic [W-1:0]              res_q;
  logic                      dz_q;
  logic [`DIVSQRT_TAG_W-1:0] tag_q;

  // Largest r with r*r not above a
  function automatic logic [W-1:0] floor_sqrt(input logic [W-1:0] a);
    int unsigned r;
    r = 0;
    while ((r + 1) * (r + 1) <= a) r++;
    return W'(r);
  endfunction

  assign in_acc   = in_valid_i & in_ready_o & ~flush_i;
  assign out_acc  = out_valid_o & out_ready_i;
  assign acc_idle = in_acc & ~busy_o;
  assign exp_res  = exp_res_q[rd_ptr_q];
  assign exp_dz   = exp_dz_q[rd_ptr_q];
  assign exp_tag  = exp_tag_q[rd_ptr_q];

  // --------------------
  // Reference model
  // --------------------
  always_ff @(posedge clk_i) begin
    if (!rst_n_i || flush_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (in_acc) begin
        exp_tag_q[wr_ptr_q] <= tag_i;
        // Zero divisor saturates the quotient
        if (op_i == OP_DIV) begin
          exp_res_q[wr_ptr_q] <= (opb_i == '0) ? '1 : opa_i / opb_i;
          exp_dz_q[wr_ptr_q]  <= (opb_i == '0);
        end else begin
          exp_res_q[wr_ptr_q] <= floor_sqrt(opa_i);
          exp_dz_q[wr_ptr_q]  <= 1'b0;
        end
        wr_ptr_q <= wr_ptr_q + 2'd1;
      end
      if (out_acc) rd_ptr_q <= rd_ptr_q + 2'd1;
      cnt_q <= cnt_q + 3'(in_acc) - 3'(out_acc);
    end
  end

  always_ff @(posedge clk_i) begin
    stall_q <= out_valid_o & ~out_ready_i;
    res_q   <= result_o;
    dz_q    <= dz_o;
    tag_q   <= tag_o;
  end

  // --------------------
  // Result checks
  // --------------------
  a_result: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    out_acc |-> result_o == exp_res)
    else begin
      $error("ERR result_o got %h exp %h", $sampled(result_o), $sampled(exp_res));
      fail_cnt++;
    end

  a_dz: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    out_acc |-> dz_o == exp_dz)
    else begin
      $error("ERR dz_o got %h exp %h", $sampled(dz_o), $sampled(exp_dz));
      fail_cnt++;
    end

  a_tag: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    out_acc |-> tag_o == exp_tag)
    else begin
      $error("ERR tag_o got %h exp %h", $sampled(tag_o), $sampled(exp_tag));
      fail_cnt++;
    end

  // Nothing comes out that was not accepted, or that was flushed
  a_spurious: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    out_valid_o |-> cnt_q != 0)
    else begin
      $error("out_valid_o raised with no operation pending");
      fail_cnt++;
    end

  // Idle unit means every accepted operation has left
  a_drained: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !busy_o |-> cnt_q == 0)
    else begin
      $error("ERR busy_o low with %h operations still pending", $sampled(cnt_q));
      fail_cnt++;
    end

  // --------------------
  // Handshake and timing
  // --------------------
  a_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i || flush_i)
    stall_q |-> out_valid_o && result_o == res_q && dz_o == dz_q && tag_o == tag_q)
    else begin
      $error("ERR stalled output changed result_o %h->%h dz_o %h->%h tag_o %h->%h",
             $sampled(res_q), $sampled(result_o), $sampled(dz_q), $sampled(dz_o),
             $sampled(tag_q), $sampled(tag_o));
      fail_cnt++;
    end

  a_lat_div: assert property (@(posedge clk_i) disable iff (!rst_n_i || flush_i)
    acc_idle && op_i == OP_DIV |-> !out_valid_o [*17] ##1 out_valid_o)
    else begin
      $error("divide result did not become valid 17 cycles after accept");
      fail_cnt++;
    end

  a_lat_sqrt: assert property (@(posedge clk_i) disable iff (!rst_n_i || flush_i)
    acc_idle && op_i != OP_DIV |-> !out_valid_o [*9] ##1 out_valid_o)
    else begin
      $error("square root result did not become valid 9 cycles after accept");
      fail_cnt++;
    end

  // Clean state after reset or flush
  a_clear: assert property (@(posedge clk_i)
    !rst_n_i || flush_i |=> !out_valid_o && !busy_o && in_ready_o)
    else begin
      $error("ERR after reset or flush out_valid_o %h busy_o %h in_ready_o %h",
             $sampled(out_valid_o), $sampled(busy_o), $sampled(in_ready_o));
      fail_cnt++;
    end

endmodule

bind divsqrt_multi divsqrt_assert u_check (.*);

/* verif/tb_divsqrt_multi.sv */
`timescale 1ns/1ps
`include "divsqrt_macros.svh"

module tb_divsqrt_multi;
  import divsqrt_pkg::*;

  localparam int unsigned W = `DIVSQRT_DATA_W;
  // Room for 40 operations of 20 cycles each and as much again for stalls
  localparam int unsigned MAX_CYCLES = 40 * 20 * 2;
  localparam int RDY_HIGH = 0;
  localparam int RDY_RAND = 1;
  localparam int RDY_LOW  = 2;
  // Zero, perfect squares, non-squares and the top value
  localparam logic [W-1:0] SQRT_CORNERS [8] = '{
    16'h0000, 16'h0001, 16'h0002, 16'h0009, 16'h0090, 16'h3fff, 16'hfe01, 16'hffff
  };

  logic                      clk_i = 1'b0;
  logic                      rst_n_i;
  logic                      in_valid_i;
  logic                      in_ready_o;
  divsqrt_op_e               op_i;
  logic [W-1:0]              opa_i;
  logic [W-1:0]              opb_i;
  logic [`DIVSQRT_TAG_W-1:0] tag_i;
  logic                      flush_i;
  logic                      out_valid_o;
  logic                      out_ready_i;
  logic [W-1:0]              result_o;
  logic                      dz_o;
  logic [`DIVSQRT_TAG_W-1:0] tag_o;
  logic                      busy_o;

  integer                    seed = 32'hdfe;
  integer                    rdy_seed = 32'hdfe;
  int                        cycle_cnt = 0;
  int                        ready_mode = RDY_HIGH;
  logic [`DIVSQRT_TAG_W-1:0] next_tag = '0;

  always #5 clk_i = ~clk_i;

  divsqrt_multi dut_i (.*);

  // Downstream ready changes only on falling edges
  always @(negedge clk_i) begin
    if (ready_mode == RDY_RAND) out_ready_i = ($random(rdy_seed) & 1) != 0;
    else out_ready_i = (ready_mode == RDY_HIGH);
  end

  // --------------------
  // Helper tasks
  // --------------------
  task automatic abort_run(input string reason);
    $display("SOME TESTS FAILED");
    $fatal(1, "%s", reason);
  endtask

  // Present one operation and keep it up until the DUT takes it
  task automatic send_op(input divsqrt_op_e op, input logic [W-1:0] a, input logic [W-1:0] b);
    @(negedge clk_i);
    in_valid_i = 1'b1;
    op_i       = op;
    opa_i      = a;
    opb_i      = b;
    tag_i      = next_tag;
    @(posedge clk_i);
    while (!in_ready_o) @(posedge clk_i);
    next_tag = next_tag + 1'b1;
  endtask

  task automatic stop_input();
    @(negedge clk_i);
    in_valid_i = 1'b0;
  endtask

  // Nothing pending and no result on offer
  task automatic wait_idle();
    @(posedge clk_i);
    while (busy_o || out_valid_o) @(posedge clk_i);
  endtask

  task automatic wait_result();
    @(posedge clk_i);
    while (!out_valid_o) @(posedge clk_i);
  endtask

  task automatic run_single(input divsqrt_op_e op, input logic [W-1:0] a, input logic [W-1:0] b);
    send_op(op, a, b);
    stop_input();
    wait_idle();
  endtask

  task automatic pulse_flush();
    @(negedge clk_i);
    flush_i = 1'b1;
    @(negedge clk_i);
    flush_i = 1'b0;
  endtask

  // First assertion failure or runaway run ends the simulation
  always @(negedge clk_i) begin
    cycle_cnt = cycle_cnt + 1;
    if (dut_i.u_check.fail_cnt != 0) begin
      abort_run("an assertion failed, stopping at the first error");
    end else if (cycle_cnt > MAX_CYCLES) begin
      abort_run($sformatf("run did not finish within %0d cycles", MAX_CYCLES));
    end
  end

  // --------------------
  // Stimulus
  // --------------------
  initial begin : stimulus
    logic [31:0] rnd;
    logic [W-1:0] divisor;
    in_valid_i  = 1'b0;
    op_i        = OP_DIV;
    opa_i       = '0;
    opb_i       = '0;
    tag_i       = '0;
    flush_i     = 1'b0;
    out_ready_i = 1'b1;
    rst_n_i     = 1'b0;
    repeat (8) @(negedge clk_i);
    rst_n_i = 1'b1;

    // Latency with out_ready held high
    run_single(OP_DIV, 16'hbeef, 16'h0013);
    run_single(OP_SQRT, 16'h9c40, 16'h0000);
    // Divide by zero
    run_single(OP_DIV, 16'h1234, 16'h0000);
    run_single(OP_DIV, 16'h0000, 16'h0000);
    for (int i = 0; i < 8; i++) run_single(OP_SQRT, SQRT_CORNERS[i], 16'h0000);

    // Random divides with every other divisor kept small
    for (int i = 0; i < 12; i++) begin
      rnd     = $random(seed);
      divisor = (i % 2 == 1) ? rnd[31:16] : {8'h00, rnd[23:16]};
      if (divisor == '0) divisor = 16'h0001;
      run_single(OP_DIV, rnd[15:0], divisor);
    end

    // Back-to-back mixed operations under random back-pressure
    ready_mode = RDY_RAND;
    for (int i = 0; i < 14; i++) begin
      rnd = $random(seed);
      send_op(divsqrt_op_e'(rnd[31]), rnd[15:0], {1'b0, rnd[30:24], rnd[23:16] & 8'hf7});
    end
    stop_input();
    wait_idle();
    ready_mode = RDY_HIGH;

    // Flush while a divide runs
    send_op(OP_DIV, 16'h7777, 16'h0005);
    stop_input();
    repeat (6) @(posedge clk_i);
    pulse_flush();
    wait_idle();

    // Flush with one result held and one more waiting in the input stage
    ready_mode = RDY_LOW;
    send_op(OP_SQRT, 16'h4000, 16'h0000);
    send_op(OP_DIV, 16'h0100, 16'h0010);
    stop_input();
    wait_result();
    pulse_flush();
    ready_mode = RDY_HIGH;
    wait_idle();

    // Unit still works after the flushes
    run_single(OP_DIV, 16'hffff, 16'h0003);

    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    if (dut_i.u_check.fail_cnt != 0) begin
      abort_run("assertion failures recorded at the end of the run");
    end else begin
      $display("ALL TESTS PASSED");
      $finish;
    end
  end

endmodule
